//--- Makefile
SRCS := $(wildcard hw/*.sv sim/*.sv)
BIN  := obj_dir/Vtb_cluster_tcdm

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) sources.f
	verilator --binary --timing --assert -j 0 -f sources.f --top-module tb_cluster_tcdm

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- hw/amo_pkg.sv
package amo_pkg;

  // Bit 5 flags an atomic, bits 4..0 hold the RISC-V AMO funct5
  typedef logic [5:0] atop_t;

  localparam logic [4:0] FUNCT_LR   = 5'b00010;
  localparam logic [4:0] FUNCT_SC   = 5'b00011;
  localparam logic [4:0] FUNCT_SWAP = 5'b00001;
  localparam logic [4:0] FUNCT_ADD  = 5'b00000;
  localparam logic [4:0] FUNCT_XOR  = 5'b00100;
  localparam logic [4:0] FUNCT_AND  = 5'b01100;
  localparam logic [4:0] FUNCT_OR   = 5'b01000;
  localparam logic [4:0] FUNCT_MIN  = 5'b10000;
  localparam logic [4:0] FUNCT_MAX  = 5'b10100;
  localparam logic [4:0] FUNCT_MINU = 5'b11000;
  localparam logic [4:0] FUNCT_MAXU = 5'b11100;

  typedef enum logic [3:0] {
    AMO_NONE = 4'h0,
    AMO_SWAP = 4'h1,
    AMO_ADD  = 4'h2,
    AMO_AND  = 4'h3,
    AMO_OR   = 4'h4,
    AMO_XOR  = 4'h5,
    AMO_MAX  = 4'h6,
    AMO_MAXU = 4'h7,
    AMO_MIN  = 4'h8,
    AMO_MINU = 4'h9
  } amo_op_e;

  // Map a core atop onto the operation run by the bank
  function automatic amo_op_e decode_atop(atop_t atop);
    amo_op_e op;
    op = AMO_NONE;
    if (atop[5]) begin
      case (atop[4:0])
        FUNCT_SWAP: op = AMO_SWAP;
        FUNCT_ADD:  op = AMO_ADD;
        FUNCT_XOR:  op = AMO_XOR;
        FUNCT_AND:  op = AMO_AND;
        FUNCT_OR:   op = AMO_OR;
        FUNCT_MIN:  op = AMO_MIN;
        FUNCT_MAX:  op = AMO_MAX;
        FUNCT_MINU: op = AMO_MINU;
        FUNCT_MAXU: op = AMO_MAXU;
        // No reservation support, these fall back to a plain access
        FUNCT_LR:   op = AMO_NONE;
        FUNCT_SC:   op = AMO_NONE;
        default:    op = AMO_NONE;
      endcase
    end
    return op;
  endfunction

endpackage

//--- hw/cluster_tcdm_interconnect.sv
module cluster_tcdm_interconnect #(
  parameter int unsigned NumMasters = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [NumMasters-1:0]                 req_i,
  input  logic [NumMasters-1:0]                 wen_i,
  input  tcdm_pkg::tcdm_addr_u [NumMasters-1:0] addr_i,
  input  tcdm_pkg::data_t [NumMasters-1:0]      wdata_i,
  input  tcdm_pkg::be_t [NumMasters-1:0]        be_i,
  input  amo_pkg::atop_t [NumMasters-1:0]       atop_i,
  output logic [NumMasters-1:0]                 gnt_o,
  output logic [NumMasters-1:0]                 rvalid_o,
  output tcdm_pkg::data_t [NumMasters-1:0]      rdata_o
);

  logic [tcdm_pkg::NB_BANKS-1:0][NumMasters-1:0] bank_gnt;
  tcdm_pkg::data_t [tcdm_pkg::NB_BANKS-1:0]      bank_rdata;

  for (genvar b = 0; b < tcdm_pkg::NB_BANKS; b++) begin : gen_bank
    logic                                sel_valid;
    logic                                sel_wen;
    tcdm_pkg::tcdm_addr_u                sel_addr;
    tcdm_pkg::data_t                     sel_wdata;
    tcdm_pkg::be_t                       sel_be;
    amo_pkg::atop_t                      sel_atop;
    logic                                ready;
    logic                                mem_req;
    logic                                mem_wen;
    logic [tcdm_pkg::MEM_ADDR_WIDTH-1:0] mem_idx;
    tcdm_pkg::data_t                     mem_wdata;
    tcdm_pkg::be_t                       mem_be;
    tcdm_pkg::data_t                     mem_rdata;

    tcdm_bank_arbiter #(
      .NumMasters (NumMasters),
      .BankIdx    (b)
    ) u_arbiter (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (req_i),
      .wen_i       (wen_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .be_i        (be_i),
      .atop_i      (atop_i),
      .ready_i     (ready),
      .gnt_o       (bank_gnt[b]),
      .sel_valid_o (sel_valid),
      .sel_wen_o   (sel_wen),
      .sel_addr_o  (sel_addr),
      .sel_wdata_o (sel_wdata),
      .sel_be_o    (sel_be),
      .sel_atop_o  (sel_atop)
    );

    tcdm_amo_unit u_amo_unit (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (sel_valid),
      .wen_i       (sel_wen),
      .addr_i      (sel_addr),
      .wdata_i     (sel_wdata),
      .be_i        (sel_be),
      .atop_i      (sel_atop),
      .ready_o     (ready),
      .mem_req_o   (mem_req),
      .mem_wen_o   (mem_wen),
      .mem_idx_o   (mem_idx),
      .mem_wdata_o (mem_wdata),
      .mem_be_o    (mem_be),
      .mem_rdata_i (mem_rdata),
      .rdata_o     (bank_rdata[b])
    );

    tcdm_sram_bank #(
      .DataWidth (tcdm_pkg::DATA_WIDTH),
      .IdxWidth  (tcdm_pkg::MEM_ADDR_WIDTH)
    ) u_sram (
      .clk_i   (clk_i),
      .req_i   (mem_req),
      .wen_i   (mem_wen),
      .idx_i   (mem_idx),
      .wdata_i (mem_wdata),
      .be_i    (mem_be),
      .rdata_o (mem_rdata)
    );
  end

  tcdm_resp_router #(
    .NumMasters (NumMasters)
  ) u_resp_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bank_gnt_i   (bank_gnt),
    .bank_rdata_i (bank_rdata),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o)
  );

endmodule

//--- hw/tcdm_amo_unit.sv
module tcdm_amo_unit (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 valid_i,
  input  logic                                 wen_i,
  input  tcdm_pkg::tcdm_addr_u                 addr_i,
  input  tcdm_pkg::data_t                      wdata_i,
  input  tcdm_pkg::be_t                        be_i,
  input  amo_pkg::atop_t                       atop_i,
  output logic                                 ready_o,
  output logic                                 mem_req_o,
  output logic                                 mem_wen_o,
  output logic [tcdm_pkg::MEM_ADDR_WIDTH-1:0]  mem_idx_o,
  output tcdm_pkg::data_t                      mem_wdata_o,
  output tcdm_pkg::be_t                        mem_be_o,
  input  tcdm_pkg::data_t                      mem_rdata_i,
  output tcdm_pkg::data_t                      rdata_o
);

  amo_pkg::amo_op_e                    op;
  logic                                is_amo;
  logic                                amo_pending_q;
  amo_pkg::amo_op_e                    op_q;
  tcdm_pkg::data_t                     operand_q;
  logic [tcdm_pkg::MEM_ADDR_WIDTH-1:0] idx_q;
  tcdm_pkg::data_t                     amo_result;

  assign op     = amo_pkg::decode_atop(atop_i);
  assign is_amo = valid_i && (op != amo_pkg::AMO_NONE);

  // Busy during the write-back cycle of an atomic
  assign ready_o = !amo_pending_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      amo_pending_q <= 1'b0;
    end else begin
      amo_pending_q <= is_amo;
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_amo) begin
      op_q      <= op;
      operand_q <= wdata_i;
      idx_q     <= addr_i.fields.word_idx;
    end
  end

  // Old word comes straight from the SRAM output register
  always_comb begin
    case (op_q)
      amo_pkg::AMO_SWAP: amo_result = operand_q;
      amo_pkg::AMO_ADD:  amo_result = mem_rdata_i + operand_q;
      amo_pkg::AMO_AND:  amo_result = mem_rdata_i & operand_q;
      amo_pkg::AMO_OR:   amo_result = mem_rdata_i | operand_q;
      amo_pkg::AMO_XOR:  amo_result = mem_rdata_i ^ operand_q;
      amo_pkg::AMO_MAX:
        amo_result = ($signed(mem_rdata_i) > $signed(operand_q)) ? mem_rdata_i : operand_q;
      amo_pkg::AMO_MAXU: amo_result = (mem_rdata_i > operand_q) ? mem_rdata_i : operand_q;
      amo_pkg::AMO_MIN:
        amo_result = ($signed(mem_rdata_i) < $signed(operand_q)) ? mem_rdata_i : operand_q;
      amo_pkg::AMO_MINU: amo_result = (mem_rdata_i < operand_q) ? mem_rdata_i : operand_q;
      default:           amo_result = mem_rdata_i;
    endcase
  end

  always_comb begin
    if (amo_pending_q) begin
      // Write-back of the full word, wen is active low
      mem_req_o   = 1'b1;
      mem_wen_o   = 1'b0;
      mem_idx_o   = idx_q;
      mem_wdata_o = amo_result;
      mem_be_o    = '1;
    end else begin
      mem_req_o   = valid_i;
      mem_wen_o   = is_amo ? 1'b1 : wen_i;
      mem_idx_o   = addr_i.fields.word_idx;
      mem_wdata_o = wdata_i;
      mem_be_o    = be_i;
    end
  end

  assign rdata_o = mem_rdata_i;

endmodule

//--- hw/tcdm_bank_arbiter.sv
module tcdm_bank_arbiter #(
  parameter int unsigned NumMasters = 4,
  parameter int unsigned BankIdx    = 0
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [NumMasters-1:0]                   req_i,
  input  logic [NumMasters-1:0]                   wen_i,
  input  tcdm_pkg::tcdm_addr_u [NumMasters-1:0]   addr_i,
  input  tcdm_pkg::data_t [NumMasters-1:0]        wdata_i,
  input  tcdm_pkg::be_t [NumMasters-1:0]          be_i,
  input  amo_pkg::atop_t [NumMasters-1:0]         atop_i,
  input  logic                                    ready_i,
  output logic [NumMasters-1:0]                   gnt_o,
  output logic                                    sel_valid_o,
  output logic                                    sel_wen_o,
  output tcdm_pkg::tcdm_addr_u                    sel_addr_o,
  output tcdm_pkg::data_t                         sel_wdata_o,
  output tcdm_pkg::be_t                           sel_be_o,
  output amo_pkg::atop_t                          sel_atop_o
);

  localparam int unsigned IdxWidth = (NumMasters > 1) ? $clog2(NumMasters) : 1;

  logic [NumMasters-1:0] bank_req;
  logic [IdxWidth-1:0]   rr_q;
  logic [IdxWidth-1:0]   win;
  logic                  found;

  // Requests that target this bank
  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      bank_req[m] = req_i[m] &&
                    (addr_i[m].fields.bank == tcdm_pkg::bank_idx_t'(BankIdx));
    end
  end

  // Search starts at the pointer and wraps around
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    win   = '0;
    for (int i = 0; i < NumMasters; i++) begin
      idx = (int'(rr_q) + i) % NumMasters;
      if (!found && bank_req[idx]) begin
        found = 1'b1;
        win   = idx[IdxWidth-1:0];
      end
    end
  end

  assign sel_valid_o = found && ready_i;

  always_comb begin
    gnt_o = '0;
    if (sel_valid_o) begin
      gnt_o[win] = 1'b1;
    end
  end

  assign sel_wen_o   = wen_i[win];
  assign sel_addr_o  = addr_i[win];
  assign sel_wdata_o = wdata_i[win];
  assign sel_be_o    = be_i[win];
  assign sel_atop_o  = atop_i[win];

  // Pointer moves past the winner on every grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (sel_valid_o) begin
      rr_q <= (int'(win) == NumMasters - 1) ? '0 : win + 1'b1;
    end
  end

endmodule

//--- hw/tcdm_pkg.sv
package tcdm_pkg;

  // Bus widths
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;
  localparam int unsigned ADDR_WIDTH = 32;

  // Bank geometry, word interleaved over the banks
  localparam int unsigned NB_BANKS       = 4;
  localparam int unsigned MEM_ADDR_WIDTH = 8;
  localparam int unsigned BANK_IDX_WIDTH = $clog2(NB_BANKS);
  localparam int unsigned BYTE_OFF_WIDTH = $clog2(BE_WIDTH);
  localparam int unsigned TAG_WIDTH      = ADDR_WIDTH - MEM_ADDR_WIDTH
                                         - BANK_IDX_WIDTH - BYTE_OFF_WIDTH;

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [BE_WIDTH-1:0]       be_t;
  typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;

  // Field view of a bus address, most significant field first
  typedef struct packed {
    logic [TAG_WIDTH-1:0]      tag;
    logic [MEM_ADDR_WIDTH-1:0] word_idx;
    bank_idx_t                 bank;
    logic [BYTE_OFF_WIDTH-1:0] byte_off;
  } tcdm_addr_fields_t;

  // One address word, seen raw on the bus or split into its fields
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    tcdm_addr_fields_t     fields;
  } tcdm_addr_u;

endpackage

//--- hw/tcdm_resp_router.sv
module tcdm_resp_router #(
  parameter int unsigned NumMasters = 4
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [tcdm_pkg::NB_BANKS-1:0][NumMasters-1:0]       bank_gnt_i,
  input  tcdm_pkg::data_t [tcdm_pkg::NB_BANKS-1:0]            bank_rdata_i,
  output logic [NumMasters-1:0]                               gnt_o,
  output logic [NumMasters-1:0]                               rvalid_o,
  output tcdm_pkg::data_t [NumMasters-1:0]                    rdata_o
);

  tcdm_pkg::bank_idx_t [NumMasters-1:0] bank_d;
  tcdm_pkg::bank_idx_t [NumMasters-1:0] bank_q;
  logic [NumMasters-1:0]                rvalid_q;

  // A master is granted by at most one bank per cycle
  always_comb begin
    gnt_o  = '0;
    bank_d = '0;
    for (int b = 0; b < tcdm_pkg::NB_BANKS; b++) begin
      for (int m = 0; m < NumMasters; m++) begin
        if (bank_gnt_i[b][m]) begin
          gnt_o[m]  = 1'b1;
          bank_d[m] = tcdm_pkg::bank_idx_t'(b);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int m = 0; m < NumMasters; m++) begin
      if (gnt_o[m]) begin
        bank_q[m] <= bank_d[m];
      end
    end
  end

  assign rvalid_o = rvalid_q;

  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      rdata_o[m] = bank_rdata_i[bank_q[m]];
    end
  end

endmodule

//--- hw/tcdm_sram_bank.sv
module tcdm_sram_bank #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned IdxWidth  = 8
) (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   wen_i,
  input  logic [IdxWidth-1:0]    idx_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [DataWidth/8-1:0] be_i,
  output logic [DataWidth-1:0]   rdata_o
);

  localparam int unsigned Depth = 2 ** IdxWidth;

  logic [DataWidth-1:0] mem [Depth];

  // wen low writes the enabled bytes, wen high reads
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (!wen_i) begin
        for (int b = 0; b < DataWidth / 8; b++) begin
          if (be_i[b]) begin
            mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx_i];
      end
    end
  end

endmodule

//--- sim/tb_cluster_tcdm.sv
module tb_cluster_tcdm;

  localparam int NumMasters = 4;
  localparam int MaxVec     = 256;
  localparam int FairRounds = 8;

  logic                                  clk;
  logic                                  rst_n;
  logic [NumMasters-1:0]                 req;
  logic [NumMasters-1:0]                 wen;
  tcdm_pkg::tcdm_addr_u [NumMasters-1:0] addr;
  tcdm_pkg::data_t [NumMasters-1:0]      wdata;
  tcdm_pkg::be_t [NumMasters-1:0]        be;
  amo_pkg::atop_t [NumMasters-1:0]       atop;
  logic [NumMasters-1:0]                 gnt;
  logic [NumMasters-1:0]                 rvalid;
  tcdm_pkg::data_t [NumMasters-1:0]      rdata;

  logic [31:0]           vec_mem [MaxVec*6];
  tcdm_pkg::data_t       ref_mem [1024];
  tcdm_pkg::data_t       exp_rdata [NumMasters];
  int                    waited [NumMasters];
  logic [NumMasters-1:0] pend;
  logic [NumMasters-1:0] granted_q;
  logic [NumMasters-1:0] data_q;
  int                    n_vec;
  int                    cycles = 0;
  int                    cycle_limit = 0;
  int unsigned           lcg_state;

  cluster_tcdm_interconnect #(
    .NumMasters (NumMasters)
  ) u_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .req_i    (req),
    .wen_i    (wen),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .be_i     (be),
    .atop_i   (atop),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Run stopped because the cycle limit was reached");
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_rdata(int m, tcdm_pkg::data_t got, tcdm_pkg::data_t exp);
    if (got !== exp) begin
      $display("error: rdata_o[%0d] got 0x%h expected 0x%h", m, got, exp);
      abort_run();
    end
  endtask

  task automatic check_wait(int m, int got, int limit);
    if (got > limit) begin
      $display("error: grants waited by master %0d got 0x%h limit 0x%h", m, got, limit);
      abort_run();
    end
  endtask

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic tcdm_pkg::data_t merge_bytes(tcdm_pkg::data_t old, tcdm_pkg::data_t wd,
                                                  tcdm_pkg::be_t b);
    tcdm_pkg::data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (b[i]) res[i*8 +: 8] = wd[i*8 +: 8];
    end
    return res;
  endfunction

  // Atomic funct5 codes of the RISC-V A extension, LR and SC excluded
  function automatic logic is_atomic(amo_pkg::atop_t at);
    return at[5] && (at[4:0] inside {5'h00, 5'h01, 5'h04, 5'h08, 5'h0c,
                                     5'h10, 5'h14, 5'h18, 5'h1c});
  endfunction

  function automatic tcdm_pkg::data_t atomic_result(logic [4:0] funct, tcdm_pkg::data_t old,
                                                    tcdm_pkg::data_t opnd);
    case (funct)
      5'h01:   return opnd;
      5'h00:   return old + opnd;
      5'h0c:   return old & opnd;
      5'h08:   return old | opnd;
      5'h04:   return old ^ opnd;
      5'h14:   return ($signed(old) > $signed(opnd)) ? old : opnd;
      5'h1c:   return (old > opnd) ? old : opnd;
      5'h10:   return ($signed(old) < $signed(opnd)) ? old : opnd;
      5'h18:   return (old < opnd) ? old : opnd;
      default: return old;
    endcase
  endfunction

  // Reference memory is indexed by the word address bits of the bus address
  task automatic apply_ref(int m);
    int              idx;
    tcdm_pkg::data_t old;
    idx       = int'(addr[m].raw[11:2]);
    old       = ref_mem[idx];
    data_q[m] = 1'b1;
    if (is_atomic(atop[m])) begin
      exp_rdata[m] = old;
      ref_mem[idx] = atomic_result(atop[m][4:0], old, wdata[m]);
    end else if (!wen[m]) begin
      data_q[m]    = 1'b0;
      ref_mem[idx] = merge_bytes(old, wdata[m], be[m]);
    end else begin
      exp_rdata[m] = old;
    end
  endtask

  task automatic set_master(int m, logic w, tcdm_pkg::tcdm_addr_u a, tcdm_pkg::data_t d,
                            tcdm_pkg::be_t b, amo_pkg::atop_t at);
    pend[m]  = 1'b1;
    req[m]   = 1'b1;
    wen[m]   = w;
    addr[m]  = a;
    wdata[m] = d;
    be[m]    = b;
    atop[m]  = at;
  endtask

  // Sample grants before the rising edge, responses at the next falling edge
  task automatic step_cycle();
    int n_gnt;
    #5;
    if ((gnt & ~pend) != '0) begin
      $display("A grant went to a master with no pending request");
      abort_run();
    end
    n_gnt = $countones(gnt);
    for (int m = 0; m < NumMasters; m++) begin
      if (gnt[m]) begin
        apply_ref(m);
        check_wait(m, waited[m], NumMasters - 1);
        waited[m] = 0;
        pend[m]   = 1'b0;
      end else if (pend[m]) begin
        waited[m] += n_gnt;
      end
    end
    granted_q = gnt;
    @(negedge clk);
    if (rvalid !== granted_q) begin
      $display("error: rvalid_o got 0x%h expected 0x%h", rvalid, granted_q);
      abort_run();
    end
    for (int m = 0; m < NumMasters; m++) begin
      if (granted_q[m]) begin
        if (data_q[m]) check_rdata(m, rdata[m], exp_rdata[m]);
        req[m] = 1'b0;
      end
    end
  endtask

  // Line fields: tag, master, op, address, wdata, be
  task automatic run_group(int first, int count);
    int                   k;
    tcdm_pkg::tcdm_addr_u a;
    for (int i = 0; i < count; i++) begin
      k     = (first + i) * 6;
      a.raw = vec_mem[k+3];
      set_master(int'(vec_mem[k+1]), !vec_mem[k+2][8], a, vec_mem[k+4],
                 tcdm_pkg::be_t'(vec_mem[k+5]), amo_pkg::atop_t'(vec_mem[k+2][5:0]));
    end
    while (pend != '0) step_cycle();
  endtask

  // Every master keeps writing distinct words of bank 0
  task automatic run_fairness();
    int                   cnt [NumMasters];
    tcdm_pkg::tcdm_addr_u a;
    for (int m = 0; m < NumMasters; m++) begin
      cnt[m] = 0;
      a.raw  = ((lcg_next() % 64) * 4 + m) << 4;
      set_master(m, 1'b0, a, lcg_next(), '1, '0);
    end
    while (pend != '0) begin
      step_cycle();
      for (int m = 0; m < NumMasters; m++) begin
        if (granted_q[m]) begin
          cnt[m]++;
          if (cnt[m] < FairRounds) begin
            a.raw = ((lcg_next() % 64) * 4 + m) << 4;
            set_master(m, 1'b0, a, lcg_next(), '1, '0);
          end
        end
      end
    end
  endtask

  initial begin
    int i;
    int j;
    lcg_state = 27;
    rst_n     = 1'b0;
    req       = '0;
    wen       = '1;
    addr      = '0;
    wdata     = '0;
    be        = '0;
    atop      = '0;
    pend      = '0;
    granted_q = '0;
    data_q    = '0;
    for (int m = 0; m < NumMasters; m++) waited[m] = 0;
    $readmemh("sim/tcdm_patterns.mem", vec_mem);
    n_vec = 0;
    while (n_vec < MaxVec && vec_mem[n_vec*6] != 32'hff) n_vec++;
    cycle_limit = (n_vec + NumMasters * FairRounds) * 12 + 20;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (3) begin
      @(negedge clk);
      if (gnt !== '0 || rvalid !== '0) begin
        $display("A grant or response appeared with no request after reset");
        abort_run();
      end
    end

    i = 0;
    while (i < n_vec) begin
      j = i;
      while (j < n_vec && vec_mem[j*6] == vec_mem[i*6]) j++;
      run_group(i, j - i);
      i = j;
    end

    run_fairness();

    $display("Test passed");
    $finish;
  end

endmodule

//--- sim/tcdm_patterns.mem
// Columns: group tag, master, op (100 write, 000 read, else atop), address, wdata, be
// Lines with one tag are issued together, tag ff ends the list
01 0 100 00000100 11223344 f
01 1 100 00000114 55667788 f
01 2 100 00000128 99aabbcc f
01 3 100 0000013c deadbeef f
02 0 100 00000100 a5a5a5a5 3
02 1 100 00000114 a5a5a5a5 c
02 2 100 00000128 a5a5a5a5 5
02 3 100 0000013c a5a5a5a5 8
03 0 000 00000100 00000000 f
03 1 000 00000114 00000000 f
03 2 000 00000128 00000000 f
03 3 000 0000013c 00000000 f
04 0 100 00000200 01010101 f
04 1 100 00000240 02020202 f
04 2 100 00000280 03030303 f
04 3 100 000002c0 04040404 f
05 0 000 00000200 00000000 f
05 1 000 00000240 00000000 f
05 2 000 00000280 00000000 f
05 3 000 000002c0 00000000 f
06 0 100 00000304 80000005 f
06 1 100 00000314 00000010 f
06 2 100 00000324 f0f0f0f0 f
06 3 100 00000334 0000000a f
07 0 034 00000304 00000003 f
07 1 020 00000314 00000005 f
07 2 02c 00000324 0ff00ff0 f
07 3 038 00000334 0000000b f
08 0 03c 00000314 00000002 f
08 1 024 00000324 0000ffff f
08 2 028 00000334 0f0f0f0f f
08 3 030 00000304 ffffffff f
09 0 021 00000304 12345678 f
09 1 022 00000314 00000000 f
09 2 123 00000324 55555555 f
09 3 000 00000334 00000000 f
0a 0 000 00000304 00000000 f
0a 1 000 00000314 00000000 f
0a 2 000 00000324 00000000 f
0a 3 000 00000334 00000000 f
ff 0 000 00000000 00000000 0

//--- sim/tcdm_props.sv
module tcdm_props (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           valid_i,
  input amo_pkg::atop_t atop_i,
  input logic           ready_o,
  input logic           mem_req_o,
  input logic           mem_wen_o,
  input tcdm_pkg::be_t  mem_be_o
);

  logic amo_grant;

  assign amo_grant = valid_i && (amo_pkg::decode_atop(atop_i) != amo_pkg::AMO_NONE);

  // Write-back cycle follows every atomic grant
  assert property (@(posedge clk_i) disable iff (!rst_n_i) amo_grant |=> !ready_o)
    else $error("ready_o high in the cycle after an atomic grant");

  // After a plain access only a new grant may reach the SRAM
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && !amo_grant) |=> (ready_o && (valid_i || !mem_req_o)))
    else $error("plain access requested the SRAM a second time");

  // Write-back stores the full word
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    amo_grant |=> (mem_req_o && !mem_wen_o && mem_be_o == '1))
    else $error("atomic write-back without a full-word write");

endmodule

bind tcdm_amo_unit tcdm_props u_props (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .valid_i   (valid_i),
  .atop_i    (atop_i),
  .ready_o   (ready_o),
  .mem_req_o (mem_req_o),
  .mem_wen_o (mem_wen_o),
  .mem_be_o  (mem_be_o)
);

//--- sources.f
hw/tcdm_pkg.sv
hw/amo_pkg.sv
hw/tcdm_sram_bank.sv
hw/tcdm_bank_arbiter.sv
hw/tcdm_amo_unit.sv
hw/tcdm_resp_router.sv
hw/cluster_tcdm_interconnect.sv
sim/tcdm_props.sv
sim/tb_cluster_tcdm.sv
